// File: include/gbprobe_defs.svh
`ifndef GBPROBE_DEFS_SVH
`define GBPROBE_DEFS_SVH

`define GB_ROUTES       4
`define GB_ROM_AW       12
`define GB_REC_AW       10
`define GB_SAMPLE_W     30
`define GB_ADR_W        15

// Host register map, byte offsets
`define GB_REG_ATOM     8'h10
`define GB_REG_ONES     8'h14
`define GB_REG_REC_CTL  8'h15
`define GB_REG_REC_CFG  8'h16
`define GB_REG_REC_STAT 8'h17
`define GB_REG_REC_ADR  8'h18
`define GB_REG_ROM_DATA 8'h30
`define GB_REG_REC_DATA 8'h40
`define GB_REG_CMP      8'h50
`define GB_REG_CMP_ROUTE 8'h51

`endif

// File: verilog/gbprobe_pkg.sv
`include "gbprobe_defs.svh"

package gbprobe_pkg;

	typedef struct packed {
		logic       write;
		logic [7:0] addr;
		logic [7:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [`GB_ADR_W-1:0] adr;
		logic [7:0]           data;
		logic                 rd;
		logic                 wr;
		logic                 cs_rom;
		logic                 cs_xram;
		logic                 phi;
		logic                 reset;
	} cart_bus_t;

	// Field order matches the recorded word layout
	typedef struct packed {
		logic                 reset;
		logic                 phi;
		logic                 wr;
		logic                 rd;
		logic                 cs_xram;
		logic                 data_oe;
		logic [7:0]           data;
		logic                 cs_rom;
		logic [`GB_ADR_W-1:0] adr;
	} bus_sample_t;

	typedef struct packed {
		logic        stop;      // Set on the final capture of a recording
		logic        spare;
		bus_sample_t sample;
	} rec_word_t;

	typedef logic [`GB_ROUTES-1:0] route_t;

	typedef struct packed {
		logic [31-`GB_SAMPLE_W:0] zero;
		bus_sample_t              sample;
	} atom_pat_t;

	typedef struct packed {
		logic [31-`GB_ROM_AW-`GB_ROUTES:0] upper;
		logic [`GB_ROM_AW-1:0]             index;
		route_t                            routes;
	} atom_ctl_t;

	typedef union packed {
		atom_pat_t pattern;
		atom_ctl_t control;
	} atom_u;

	typedef struct packed {
		bus_sample_t value;
		bus_sample_t mask;
		route_t      level_routes;
		route_t      edge_routes;
	} cmp_cfg_t;

	typedef struct packed {
		route_t start_mask;
		route_t stop_mask;
		route_t cap_mask;
		logic   cyclic;
	} rec_cfg_t;

	typedef struct packed {
		logic                  start_now;
		logic                  stop_now;
		logic                  cap_now;
		logic                  adr_set;
		logic [`GB_REC_AW-1:0] adr_value;
	} rec_cmd_t;

endpackage

// File: verilog/host_regs.sv
`timescale 1ns/10ps
`include "gbprobe_defs.svh"

module host_regs (
	input  logic                   pllclk,
	input  logic                   f_reset,
	input  gbprobe_pkg::host_req_t host_req,
	input  logic                   req,
	output logic                   ack,
	output logic [7:0]             rdata,
	output gbprobe_pkg::cmp_cfg_t  cmp_cfg,
	output gbprobe_pkg::route_t    ones,
	output gbprobe_pkg::rec_cfg_t  rec_cfg,
	output gbprobe_pkg::rec_cmd_t  rec_cmd,
	output logic                   rom_we,
	output logic [`GB_ROM_AW-1:0]  rom_adr,
	output logic [7:0]             rom_wdata,
	input  gbprobe_pkg::rec_word_t rec_rdata,
	input  logic                   rec_running,
	input  logic [`GB_REC_AW-1:0]  rec_adr
);

	gbprobe_pkg::host_req_t hreq_q;
	gbprobe_pkg::atom_u     atom;
	logic                   req_q;
	logic                   pend;
	logic [7:0]             rd_mux;
	logic [15:0]            rec_adr_ext;

	assign rec_adr_ext = {{(16-`GB_REC_AW){1'b0}}, rec_adr};
	assign rom_adr     = atom.control.index;
	assign rom_wdata   = hreq_q.wdata;     // Held stable by the host until ack

	always_ff @(posedge pllclk) begin
		hreq_q <= host_req;
	end

	always_comb begin
		rd_mux = 8'hff;
		if ({hreq_q.addr[7:2], 2'b00} == `GB_REG_ATOM)
			rd_mux = atom[{hreq_q.addr[1:0], 3'b000} +: 8];
		else if ({hreq_q.addr[7:2], 2'b00} == `GB_REG_REC_DATA)
			rd_mux = rec_rdata[{hreq_q.addr[1:0], 3'b000} +: 8];
		else if ({hreq_q.addr[7:1], 1'b0} == `GB_REG_REC_ADR)
			rd_mux = rec_adr_ext[{hreq_q.addr[0], 3'b000} +: 8];
		else if (hreq_q.addr == `GB_REG_REC_CFG)
			rd_mux = {7'b0, rec_cfg.cyclic};
		else if (hreq_q.addr == `GB_REG_REC_STAT)
			rd_mux = {7'b0, rec_running};
	end

	always_ff @(posedge pllclk) begin
		req_q   <= req;
		rom_we  <= 1'b0;
		rec_cmd <= '0;

		if (req_q && !ack && !pend)
			pend <= 1'b1;                  // One action per request
		if (!req_q)
			ack <= 1'b0;

		if (pend) begin
			pend  <= 1'b0;
			ack   <= 1'b1;
			rdata <= rd_mux;

			if (hreq_q.write && {hreq_q.addr[7:2], 2'b00} == `GB_REG_ATOM)
				atom[{hreq_q.addr[1:0], 3'b000} +: 8] <= hreq_q.wdata;

			if (hreq_q.write) begin
				case (hreq_q.addr)
				`GB_REG_ONES:
					ones <= atom.control.routes;
				`GB_REG_REC_CTL: begin
					if (hreq_q.wdata[0])
						rec_cfg.start_mask <= atom.control.routes;
					if (hreq_q.wdata[1])
						rec_cfg.stop_mask <= atom.control.routes;
					if (hreq_q.wdata[2])
						rec_cfg.cap_mask <= atom.control.routes;
					rec_cmd.start_now <= hreq_q.wdata[3];
					rec_cmd.stop_now  <= hreq_q.wdata[4];
					rec_cmd.cap_now   <= hreq_q.wdata[5];
					rec_cmd.adr_set   <= hreq_q.wdata[7];
					rec_cmd.adr_value <= atom.control.index[`GB_REC_AW-1:0];
				end
				`GB_REG_REC_CFG:
					rec_cfg.cyclic <= hreq_q.wdata[0];
				`GB_REG_ROM_DATA:
					rom_we <= 1'b1;
				`GB_REG_CMP: begin
					if (hreq_q.wdata[0])
						cmp_cfg.value <= atom.pattern.sample;
					if (hreq_q.wdata[4])
						cmp_cfg.mask <= atom.pattern.sample;
				end
				`GB_REG_CMP_ROUTE: begin
					if (hreq_q.wdata[0])
						cmp_cfg.level_routes <= atom.control.routes;
					if (hreq_q.wdata[4])
						cmp_cfg.edge_routes <= atom.control.routes;
				end
				default: ;
				endcase
			end
		end

		if (f_reset) begin
			req_q   <= 1'b0;
			pend    <= 1'b0;
			ack     <= 1'b0;
			rom_we  <= 1'b0;
			atom    <= '0;
			ones    <= '0;
			cmp_cfg <= '0;
			rec_cfg <= '0;
			rec_cmd <= '0;
		end
	end

endmodule

// File: verilog/cart_emu.sv
`timescale 1ns/10ps
`include "gbprobe_defs.svh"

module cart_emu (
	input  logic                     pllclk,
	input  logic                     f_reset,
	input  gbprobe_pkg::cart_bus_t   cart,
	input  logic                     rom_we,
	input  logic [`GB_ROM_AW-1:0]    rom_adr,
	input  logic [7:0]               rom_wdata,
	output logic [7:0]               rom_data,
	output logic                     rom_oe,
	output gbprobe_pkg::bus_sample_t sample
);

	gbprobe_pkg::cart_bus_t cart_q;
	logic                   prev_cs_rom;
	logic                   prev_cs_xram;
	logic [`GB_ROM_AW-1:0]  adr_latch;
	logic                   rd_act;
	logic                   rd_act_q;
	logic [7:0]             rom [0:(1 << `GB_ROM_AW)-1];

	assign rd_act = cart_q.rd && cart_q.cs_rom;

	always_ff @(posedge pllclk) begin
		cart_q       <= cart;
		prev_cs_rom  <= cart_q.cs_rom;
		prev_cs_xram <= cart_q.cs_xram;
		rd_act_q     <= rd_act;
		rom_oe       <= rd_act && rd_act_q;

		// The console glitches its address lines when the data lines toggle,
		// so the ROM index is frozen at chip-select rise to break that loop
		if ((cart_q.cs_rom && !prev_cs_rom) || (cart_q.cs_xram && !prev_cs_xram))
			adr_latch <= cart_q.adr[`GB_ROM_AW-1:0];

		if (f_reset) begin
			cart_q       <= '0;
			prev_cs_rom  <= 1'b0;
			prev_cs_xram <= 1'b0;
			rd_act_q     <= 1'b0;
			rom_oe       <= 1'b0;
			adr_latch    <= '0;
		end
	end

	always_ff @(posedge pllclk) begin
		if (rom_we)
			rom[rom_adr] <= rom_wdata;
		rom_data <= rom[adr_latch];
	end

	always_comb begin
		sample.reset   = cart_q.reset;
		sample.phi     = cart_q.phi;
		sample.wr      = cart_q.wr;
		sample.rd      = cart_q.rd;
		sample.cs_xram = cart_q.cs_xram;
		sample.data_oe = rom_oe;              // Our own drive, not a cart input
		sample.data    = cart_q.data;
		sample.cs_rom  = cart_q.cs_rom;
		sample.adr     = cart_q.adr;
	end

endmodule

// File: verilog/bus_trigger.sv
`timescale 1ns/10ps
`include "gbprobe_defs.svh"

module bus_trigger (
	input  logic                     pllclk,
	input  logic                     f_reset,
	input  gbprobe_pkg::bus_sample_t sample,
	input  gbprobe_pkg::cmp_cfg_t    cmp_cfg,
	input  gbprobe_pkg::route_t      ones,
	output gbprobe_pkg::route_t      route,
	output gbprobe_pkg::bus_sample_t sample_d
);

	logic                [`GB_SAMPLE_W-1:0] diff;
	logic                match;
	logic                prev_match;
	gbprobe_pkg::route_t route_next;

	assign diff  = (sample ^ cmp_cfg.value) & cmp_cfg.mask;
	assign match = diff == '0;

	always_comb begin
		route_next = ones;
		if (match)
			route_next = route_next | cmp_cfg.level_routes;
		if (match && !prev_match)
			route_next = route_next | cmp_cfg.edge_routes;  // First cycle of a run only
	end

	always_ff @(posedge pllclk) begin
		prev_match <= match;
		route      <= route_next;

		if (f_reset) begin
			prev_match <= 1'b0;
			route      <= '0;
		end
	end

	// Keeps the recorded sample in step with the route it produced
	always_ff @(posedge pllclk) begin
		sample_d <= sample;
	end

endmodule

// File: verilog/recorder.sv
`timescale 1ns/10ps
`include "gbprobe_defs.svh"

module recorder (
	input  logic                     pllclk,
	input  logic                     f_reset,
	input  gbprobe_pkg::route_t      route,
	input  gbprobe_pkg::bus_sample_t sample_d,
	input  gbprobe_pkg::rec_cfg_t    rec_cfg,
	input  gbprobe_pkg::rec_cmd_t    rec_cmd,
	input  logic [`GB_REC_AW-1:0]    rd_adr,
	output gbprobe_pkg::rec_word_t   rec_rdata,
	output logic                     rec_running,
	output logic [`GB_REC_AW-1:0]    rec_adr
);

	gbprobe_pkg::rec_word_t mem [0:(1 << `GB_REC_AW)-1];
	gbprobe_pkg::rec_word_t wr_word;
	logic                   start;
	logic                   stop;
	logic                   capture;

	always_comb begin
		start   = |(route & rec_cfg.start_mask) || rec_cmd.start_now;
		stop    = |(route & rec_cfg.stop_mask) || rec_cmd.stop_now;
		capture = |(route & rec_cfg.cap_mask) || rec_cmd.cap_now;

		if (start && rec_running)
			start = 1'b0;
		if (stop && !rec_running)
			stop = 1'b0;

		// The starting cycle records its own sample
		capture = capture && (rec_running || start);

		if (capture && !rec_cfg.cyclic && &rec_adr)
			stop = 1'b1;                    // Memory full
		if (stop)
			capture = 1'b1;

		wr_word.stop   = stop;
		wr_word.spare  = 1'b0;
		wr_word.sample = sample_d;
	end

	always_ff @(posedge pllclk) begin
		if (capture)
			rec_adr <= rec_adr + 1'b1;
		if (rec_cmd.adr_set)
			rec_adr <= rec_cmd.adr_value;

		if (stop)
			rec_running <= 1'b0;
		else if (start)
			rec_running <= 1'b1;

		if (f_reset) begin
			rec_adr     <= '0;
			rec_running <= 1'b0;
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture)
			mem[rec_adr] <= wr_word;
		rec_rdata <= mem[rd_adr];
	end

endmodule

// File: verilog/gbprobe_top.sv
`timescale 1ns/10ps
`include "gbprobe_defs.svh"

module gbprobe_top (
	input  logic                   pllclk,
	input  logic                   f_reset,
	input  gbprobe_pkg::host_req_t host_req,
	input  logic                   req,
	output logic                   ack,
	output logic [7:0]             rdata,
	input  gbprobe_pkg::cart_bus_t cart,
	output logic [7:0]             rom_data,
	output logic                   rom_oe
);

	gbprobe_pkg::cmp_cfg_t    cmp_cfg;
	gbprobe_pkg::route_t      ones;
	gbprobe_pkg::rec_cfg_t    rec_cfg;
	gbprobe_pkg::rec_cmd_t    rec_cmd;
	logic                     rom_we;
	logic [`GB_ROM_AW-1:0]    rom_adr;
	logic [7:0]               rom_wdata;
	gbprobe_pkg::rec_word_t   rec_rdata;
	logic                     rec_running;
	logic [`GB_REC_AW-1:0]    rec_adr;
	gbprobe_pkg::bus_sample_t sample;
	gbprobe_pkg::route_t      route;
	gbprobe_pkg::bus_sample_t sample_d;

	host_regs u_host_regs (
		.pllclk(pllclk), .f_reset(f_reset),
		.host_req(host_req), .req(req), .ack(ack), .rdata(rdata),
		.cmp_cfg(cmp_cfg), .ones(ones), .rec_cfg(rec_cfg), .rec_cmd(rec_cmd),
		.rom_we(rom_we), .rom_adr(rom_adr), .rom_wdata(rom_wdata),
		.rec_rdata(rec_rdata), .rec_running(rec_running), .rec_adr(rec_adr)
	);

	cart_emu u_cart_emu (
		.pllclk(pllclk), .f_reset(f_reset), .cart(cart),
		.rom_we(rom_we), .rom_adr(rom_adr), .rom_wdata(rom_wdata),
		.rom_data(rom_data), .rom_oe(rom_oe), .sample(sample)
	);

	bus_trigger u_bus_trigger (
		.pllclk(pllclk), .f_reset(f_reset), .sample(sample),
		.cmp_cfg(cmp_cfg), .ones(ones), .route(route), .sample_d(sample_d)
	);

	// Readback address shares the atom index with the ROM write address
	recorder u_recorder (
		.pllclk(pllclk), .f_reset(f_reset), .route(route), .sample_d(sample_d),
		.rec_cfg(rec_cfg), .rec_cmd(rec_cmd), .rd_adr(rom_adr[`GB_REC_AW-1:0]),
		.rec_rdata(rec_rdata), .rec_running(rec_running), .rec_adr(rec_adr)
	);

endmodule

// File: tb/gbprobe_clkgen.sv
`timescale 1ns/10ps

module gbprobe_clkgen (
	output logic pllclk,
	output logic f_reset
);

	initial begin
		pllclk = 1'b0;
		forever #4 pllclk = ~pllclk;    // 8 ns period
	end

	initial begin
		f_reset = 1'b1;
		repeat (10) @(posedge pllclk);
		#1 f_reset = 1'b0;
	end

endmodule

// File: tb/gbprobe_assertions.sv
`timescale 1ns/10ps

module gbprobe_assertions (
	input logic pllclk,
	input logic f_reset,
	input logic req,
	input logic ack,
	input logic rom_oe
);

	ack_needs_req: assert property (@(posedge pllclk) disable iff (f_reset)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a pending request");

	ack_held_by_req: assert property (@(posedge pllclk) disable iff (f_reset)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

	// The cart data lines stay undriven while the probe is held in reset
	oe_off_in_reset: assert property (@(posedge pllclk) $past(f_reset) |-> !rom_oe)
		else $error("rom_oe high during reset");

endmodule

bind gbprobe_top gbprobe_assertions u_assertions (
	.pllclk(pllclk), .f_reset(f_reset), .req(req), .ack(ack), .rom_oe(rom_oe)
);

// File: tb/gbprobe_tb.sv
`timescale 1ns/10ps

module gbprobe_tb;

	logic                   pllclk;
	logic                   f_reset;
	gbprobe_pkg::host_req_t host_req;
	logic                   req;
	logic                   ack;
	logic [7:0]             rdata;
	gbprobe_pkg::cart_bus_t cart;
	logic [7:0]             rom_data;
	logic                   rom_oe;
	string                  lines[$];
	string                  names[$];
	string                  test_name;
	int                     errors;
	int                     test_errors;

	gbprobe_clkgen u_clkgen (.pllclk(pllclk), .f_reset(f_reset));

	gbprobe_top uut (
		.pllclk(pllclk), .f_reset(f_reset), .host_req(host_req), .req(req),
		.ack(ack), .rdata(rdata), .cart(cart), .rom_data(rom_data), .rom_oe(rom_oe)
	);

	task automatic next_cycle;
		@(posedge pllclk);
		#1;                                 // Inputs change just after the edge
	endtask

	task automatic note_error;
		errors++;
		test_errors++;
	endtask

	task automatic host_access(input logic write, input logic [7:0] addr,
		input logic [7:0] wdata, output logic [7:0] data);
		int n;
		host_req.write = write;
		host_req.addr  = addr;
		host_req.wdata = wdata;
		req = 1'b1;
		n = 0;
		while (!ack && n < 16) begin
			next_cycle();
			n++;
		end
		data = rdata;
		if (!ack) begin
			$display("No ack from the host port at offset %h in %s", addr, test_name);
			note_error();
		end
		req = 1'b0;
		n = 0;
		while (ack && n < 16) begin
			next_cycle();
			n++;
		end
		if (ack) begin
			$display("ack stayed high after req fell in %s", test_name);
			note_error();
		end
	endtask

	task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %h actual %h", test_name, exp, act);
			note_error();
		end
	endtask

	task automatic check_rec_word(input gbprobe_pkg::rec_word_t exp,
		input gbprobe_pkg::rec_word_t act);
		if (act !== exp) begin
			$display("Fail %s expected %h actual %h", test_name, exp, act);
			note_error();
		end
	endtask

	task automatic check_rom(input logic [7:0] exp_data, input logic exp_oe,
		input logic [7:0] act_data, input logic act_oe);
		if ({act_oe, act_data} !== {exp_oe, exp_data}) begin
			$display("Fail %s expected %h actual %h", test_name, {exp_oe, exp_data},
				{act_oe, act_data});
			note_error();
		end
	endtask

	initial begin
		int                     fd;
		int                     cyc;
		int                     tests_done;
		string                  line;
		string                  op;
		string                  tok;
		logic [31:0]            v1;
		logic [31:0]            v2;
		logic [7:0]             b;
		gbprobe_pkg::rec_word_t word;
		host_req     = '0;
		req          = 1'b0;
		cart         = '0;
		cart.rd      = 1'b1;                // A ROM read held through reset
		cart.cs_rom  = 1'b1;
		errors       = 0;
		tests_done   = 0;
		fd = $fopen("tb/gbprobe_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			$display("tests failed");
			$finish;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					lines.push_back(line);
					if (line[0] == "E") begin
						void'($sscanf(line, "%s %s", op, tok));
						names.push_back(tok);
					end
				end
			end
			$fclose(fd);
			test_name   = (names.size() > 0) ? names[0] : "unnamed";
			test_errors = 0;
			@(negedge f_reset);
			cart = '0;
			next_cycle();
			foreach (lines[i]) begin
				void'($sscanf(lines[i], "%s %h %h", op, v1, v2));
				if (op == "W") begin
					host_access(1'b1, v1[7:0], v2[7:0], b);
				end else if (op == "R") begin
					host_access(1'b0, v1[7:0], 8'h00, b);
					check_byte(v2[7:0], b);
				end else if (op == "A") begin
					for (int k = 0; k < 4; k++)
						host_access(1'b1, 8'h10 + 8'(k), v1[8*k +: 8], b);
				end else if (op == "C") begin
					void'($sscanf(lines[i], "%s %h %d", op, v1, cyc));
					cart = gbprobe_pkg::cart_bus_t'(v1[28:0]);
					repeat (cyc) next_cycle();
				end else if (op == "K") begin
					check_rom(v1[7:0], v2[0], rom_data, rom_oe);
				end else if (op == "D") begin
					host_access(1'b1, 8'h10, {v1[3:0], 4'h0}, b);   // Atom index selects the word
					host_access(1'b1, 8'h11, v1[11:4], b);
					for (int k = 0; k < 4; k++) begin
						host_access(1'b0, 8'h40 + 8'(k), 8'h00, b);
						word[8*k +: 8] = b;
					end
					check_rec_word(gbprobe_pkg::rec_word_t'(v2), word);
				end else if (op == "E") begin
					if (test_errors == 0)
						$display("%s ok", test_name);
					else
						$display("%s had %0d errors", test_name, test_errors);
					tests_done++;
					test_errors = 0;
					if (tests_done < names.size())
						test_name = names[tests_done];
				end else begin
					$display("Unknown stimulus line %s", lines[i]);
					errors++;
				end
			end
			$display("%0d tests run, %0d errors", tests_done, errors);
			if (errors == 0)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

	initial begin
		@(negedge f_reset);
		repeat (lines.size() * 64) @(posedge pllclk);
		$display("Watchdog expired before the stimulus finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: tb/gbprobe_stim.txt
# W addr data | R addr expected | A atom32 | C cart29 cycles(decimal)
# K rom_data rom_oe | D rec_index expected32 | E test_name
R 17 00
R 18 00
R 19 00
A 44332211
R 10 11
R 13 44
R 20 ff
R 60 ff
E reset_and_regs
A 00001230
W 30 a5
C 48c028 6
K a5 1
C 0 3
K a5 0
E rom_read
A 00000123
W 50 01
A 00007fff
W 50 10
A 00000001
W 51 01
W 15 05
C 48d692 5
C 0 3
W 15 10
R 18 06
D 000 185a0123
D 004 185a0123
D 005 80000000
E level_capture
A 00000002
W 51 10
W 15 85
C 48d692 4
C 0 3
C 48d692 4
C 0 3
W 15 10
R 18 03
D 001 185a0123
D 002 80000000
E edge_capture
A 00003fc4
W 14 01
W 15 84
W 15 08
R 17 00
R 18 00
R 19 00
D 3ff 80000000
E full_stop
A 00003fc0
W 14 00
W 16 01
A 00003fc1
W 15 84
W 15 08
R 17 01
C 48d692 6
C 0 3
W 15 10
R 17 00
R 18 03
R 19 00
D 3ff 185a0123
D 002 80000000
E cyclic_wrap

// File: verilog.f
+incdir+include
verilog/gbprobe_pkg.sv
verilog/host_regs.sv
verilog/cart_emu.sv
verilog/bus_trigger.sv
verilog/recorder.sv
verilog/gbprobe_top.sv
tb/gbprobe_clkgen.sv
tb/gbprobe_assertions.sv
tb/gbprobe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module gbprobe_tb \
	-f verilog.f -o gbprobe_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/gbprobe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0
